/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pueo_turf_ctl_tb -f pueo_turf_ctl.f
	./obj_dir/Vpueo_turf_ctl_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/pueo_turf_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module pueo_turf_ctl (
    input  wire                       ps_clk,
    input  wire                       arst_n_i,

    // Processor EMIO GPIO
    input  wire turf_pkg::gpio_word_t emio_gpio_o_i,
    input  wire turf_pkg::gpio_word_t emio_gpio_t_i,
    output wire turf_pkg::gpio_word_t emio_gpio_i_o,

    // TURFIO reset pins, split into value, enable and pad input
    input  wire turf_pkg::tio_bits_t  tresetb_i,
    output wire turf_pkg::tio_bits_t  tresetb_o,
    output wire turf_pkg::tio_bits_t  tresetb_oe_o,

    // GPS. Timepulse 0 belongs to the time logic, only TP1 is mapped here
    input  wire [1:0]                 gps_timepulse_i,
    output wire [1:0]                 gps_extint_o,

    // Status flags
    input  wire                       pps_pulse_i,
    input  wire                       hsk_irq_i,
    input  wire                       hsk_complete_i,
    input  wire                       uart_irq_b_i,
    input  wire turf_pkg::tio_bits_t  aurora_up_i,

    // Register read port
    input  wire                       rd_stb_i,
    input  wire turf_pkg::reg_addr_t  rd_addr_i,
    output wire                       rd_valid_o,
    output wire turf_pkg::reg_data_t  rd_data_o,

    // UART debug 16x ticks
    output wire                       hsk_tick_o,
    output wire                       gps_tick_o
);

    ////////////////////////////////////////
    // GPIO mapping
    ////////////////////////////////////////

    turf_gpio_map u_gpio_map (
        .ps_clk           (ps_clk),
        .arst_n_i         (arst_n_i),
        .gpio_o_i         (emio_gpio_o_i),
        .gpio_t_i         (emio_gpio_t_i),
        .gpio_in_o        (emio_gpio_i_o),
        .tresetb_i        (tresetb_i),
        .gps_timepulse1_i (gps_timepulse_i[1]),
        .pps_pulse_i      (pps_pulse_i),
        .hsk_irq_i        (hsk_irq_i),
        .hsk_complete_i   (hsk_complete_i),
        .uart_irq_b_i     (uart_irq_b_i),
        .tresetb_o        (tresetb_o),
        .tresetb_oe_o     (tresetb_oe_o),
        .gps_extint_o     (gps_extint_o)
    );

    ////////////////////////////////////////
    // ID and status registers
    ////////////////////////////////////////

    // GPIO read returns the same synchronized word the processor sees
    turf_id_regs u_id_regs (
        .ps_clk      (ps_clk),
        .arst_n_i    (arst_n_i),
        .rd_stb_i    (rd_stb_i),
        .rd_addr_i   (rd_addr_i),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o),
        .gpio_in_i   (emio_gpio_i_o),
        .aurora_up_i (aurora_up_i)
    );

    ////////////////////////////////////////
    // Baud ticks
    ////////////////////////////////////////

    uart_baud_tick #(
        .INCREMENT (turf_pkg::HSK_TICK_ADD),
        .ACC_WIDTH (turf_pkg::HSK_TICK_WIDTH)
    ) u_hsk_tick (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (hsk_tick_o)
    );

    uart_baud_tick #(
        .INCREMENT (turf_pkg::GPS_TICK_ADD),
        .ACC_WIDTH (turf_pkg::GPS_TICK_WIDTH)
    ) u_gps_tick (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (gps_tick_o)
    );

endmodule

`default_nettype wire

/* logic/turf_gpio_map.sv */
`timescale 1ns/1ps
`default_nettype none

module turf_gpio_map (
    input  wire                       ps_clk,
    input  wire                       arst_n_i,
    // Processor side
    input  wire turf_pkg::gpio_word_t gpio_o_i,
    input  wire turf_pkg::gpio_word_t gpio_t_i,
    output turf_pkg::gpio_word_t      gpio_in_o,
    // Pads and status flags, all asynchronous
    input  wire turf_pkg::tio_bits_t  tresetb_i,
    input  wire                       gps_timepulse1_i,
    input  wire                       pps_pulse_i,
    input  wire                       hsk_irq_i,
    input  wire                       hsk_complete_i,
    input  wire                       uart_irq_b_i,
    // Pin controls
    output turf_pkg::tio_bits_t       tresetb_o,
    output turf_pkg::tio_bits_t       tresetb_oe_o,
    output logic [1:0]                gps_extint_o
);

    localparam int NUM_TIO    = $bits(turf_pkg::tio_bits_t);
    localparam int NUM_EXTINT = 2;
    // Four reset pads plus five single-bit flags
    localparam int NUM_SYNC   = NUM_TIO + 5;

    logic [NUM_SYNC-1:0] pad_async;
    logic [NUM_SYNC-1:0] pad_meta;
    logic [NUM_SYNC-1:0] pad_sync;

    turf_pkg::tio_bits_t tio_sync;
    logic                tp1_sync;
    logic                pps_sync;
    logic                hsk_complete_sync;
    logic                hsk_irq_sync;
    logic                uart_irq_sync;

    ////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////

    assign pad_async = {tresetb_i, gps_timepulse1_i, pps_pulse_i,
                        hsk_complete_i, hsk_irq_i, uart_irq_b_i};

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pad_meta <= '0;
            pad_sync <= '0;
        end else begin
            pad_meta <= pad_async;
            pad_sync <= pad_meta;
        end
    end

    assign {tio_sync, tp1_sync, pps_sync,
            hsk_complete_sync, hsk_irq_sync, uart_irq_sync} = pad_sync;

    // Processor input word, unused bits read zero
    always_comb begin
        gpio_in_o = '0;
        gpio_in_o[turf_pkg::TIO_RESET_LSB +: NUM_TIO] = tio_sync;
        gpio_in_o[turf_pkg::TIMEPULSE1_BIT]           = tp1_sync;
        gpio_in_o[turf_pkg::PPS_BIT]                  = pps_sync;
        gpio_in_o[turf_pkg::HSK_COMPLETE_BIT]         = hsk_complete_sync;
        gpio_in_o[turf_pkg::HSK_IRQ_BIT]              = hsk_irq_sync;
        gpio_in_o[turf_pkg::UART_IRQ_BIT]             = uart_irq_sync;
    end

    ////////////////////////////////////////
    // Pin controls
    ////////////////////////////////////////

    // Tristate bit high means the pad floats, so enable is its inverse.
    // Out of reset every enable is low and the resets are released.
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tresetb_o    <= '0;
            tresetb_oe_o <= '0;
            gps_extint_o <= '0;
        end else begin
            tresetb_o    <= gpio_o_i[turf_pkg::TIO_RESET_LSB +: NUM_TIO];
            tresetb_oe_o <= ~gpio_t_i[turf_pkg::TIO_RESET_LSB +: NUM_TIO];
            // EXTINT only driven while its tristate bit is low
            gps_extint_o <= gpio_o_i[turf_pkg::EXTINT_LSB +: NUM_EXTINT] &
                            ~gpio_t_i[turf_pkg::EXTINT_LSB +: NUM_EXTINT];
        end
    end

    // Reserved input bits never carry anything
    spare_bits_zero: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        gpio_in_o[9:3] == '0
    ) else $error("gpio_in_o reserved bits 9:3 not zero");

endmodule

`default_nettype wire

/* logic/turf_id_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module turf_id_regs (
    input  wire                       ps_clk,
    input  wire                       arst_n_i,
    // Read port, one strobe gives one response a cycle later
    input  wire                       rd_stb_i,
    input  wire turf_pkg::reg_addr_t  rd_addr_i,
    output logic                      rd_valid_o,
    output turf_pkg::reg_data_t       rd_data_o,
    // Status sources
    input  wire turf_pkg::gpio_word_t gpio_in_i,
    input  wire turf_pkg::tio_bits_t  aurora_up_i
);

    localparam int NUM_TIO = $bits(turf_pkg::tio_bits_t);

    wire turf_pkg::bridge_valid_t bridge_valid;
    turf_pkg::reg_data_t          rd_mux;

    ////////////////////////////////////////
    // Bridge valid map
    ////////////////////////////////////////

    // Per TURFIO, from the top: two unimplemented bridges, Aurora link,
    // then the "none" bridge which is always valid
    for (genvar k = 0; k < NUM_TIO; k++) begin : g_bridge_valid
        assign bridge_valid[4*k +: 4] = {2'b00, aurora_up_i[k], 1'b1};
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (rd_addr_i)
            turf_pkg::ADDR_IDENT: begin
                rd_mux = turf_pkg::IDENT_WORD;
            end
            turf_pkg::ADDR_DATEVERSION: begin
                rd_mux = turf_pkg::DATEVERSION;
            end
            turf_pkg::ADDR_BRIDGE_VALID: begin
                rd_mux = turf_pkg::reg_data_t'(bridge_valid);
            end
            turf_pkg::ADDR_GPIO_IN: begin
                rd_mux = turf_pkg::reg_data_t'(gpio_in_i);
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // Data only updates on a strobe, so it holds between responses
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_o <= 1'b0;
            rd_data_o  <= '0;
        end else begin
            rd_valid_o <= rd_stb_i;
            if (rd_stb_i) begin
                rd_data_o <= rd_mux;
            end
        end
    end

    // Every strobe must carry a defined register address
    rd_addr_known: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        rd_stb_i |-> !$isunknown(rd_addr_i)
    ) else $error("rd_addr_i unknown during a read strobe");

endmodule

`default_nettype wire

/* logic/turf_pkg.sv */
`default_nettype none

package turf_pkg;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Processor GPIO value, tristate or input word
    typedef logic [15:0] gpio_word_t;

    // Register bank address and read data
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One bit per TURFIO, A in bit 0
    typedef logic [3:0]  tio_bits_t;

    // Crate-bridge valid map, four bits per TURFIO
    typedef logic [15:0] bridge_valid_t;

    ////////////////////////////////////////
    // GPIO bit map
    ////////////////////////////////////////

    // Top nibble is the TURFIO resets
    localparam int TIO_RESET_LSB    = 12;
    localparam int TIMEPULSE1_BIT   = 11;
    localparam int PPS_BIT          = 10;
    // Output side only, GPS EXTINT1/EXTINT0
    localparam int EXTINT_LSB       = 8;
    localparam int HSK_COMPLETE_BIT = 2;
    localparam int HSK_IRQ_BIT      = 1;
    localparam int UART_IRQ_BIT     = 0;

    ////////////////////////////////////////
    // Identification
    ////////////////////////////////////////

    // "TURF" in ASCII
    localparam reg_data_t   IDENT_WORD    = 32'h5455_5246;
    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd6;
    localparam logic [7:0]  VER_REV       = 8'd0;
    localparam logic [15:0] FIRMWARE_DATE = 16'h0000;
    localparam logic        REV_B         = 1'b1;

    // Rev flag, 15 date bits, then major/minor/rev
    localparam reg_data_t DATEVERSION = {REV_B, FIRMWARE_DATE[14:0],
                                         VER_MAJOR, VER_MINOR, VER_REV};

    // Register map
    localparam reg_addr_t ADDR_IDENT        = 2'd0;
    localparam reg_addr_t ADDR_DATEVERSION  = 2'd1;
    localparam reg_addr_t ADDR_BRIDGE_VALID = 2'd2;
    localparam reg_addr_t ADDR_GPIO_IN      = 2'd3;

    ////////////////////////////////////////
    // UART 16x baud ticks
    ////////////////////////////////////////

    // 8 MHz from 100 MHz, 82/1024 is within 0.1%
    localparam int unsigned HSK_TICK_ADD   = 82;
    localparam int unsigned HSK_TICK_WIDTH = 10;
    // 16x of 38400 baud
    localparam int unsigned GPS_TICK_ADD   = 25;
    localparam int unsigned GPS_TICK_WIDTH = 12;

endpackage

`default_nettype wire

/* logic/uart_baud_tick.sv */
`timescale 1ns/1ps
`default_nettype none

// Fractional 16x baud tick. The carry out of an ACC_WIDTH-bit phase
// accumulator fires INCREMENT times per 2^ACC_WIDTH cycles.
// INCREMENT must stay below half of 2^ACC_WIDTH for single-cycle ticks.
module uart_baud_tick #(
    parameter int unsigned INCREMENT = 82,
    parameter int unsigned ACC_WIDTH = 10
) (
    input  wire  ps_clk,
    input  wire  arst_n_i,
    output logic tick_o
);

    localparam logic [ACC_WIDTH:0] ADD_VALUE = (ACC_WIDTH + 1)'(INCREMENT);

    // Extra top bit is the carry
    logic [ACC_WIDTH:0] acc;
    logic [ACC_WIDTH:0] acc_next;

    ////////////////////////////////////////
    // Phase accumulator
    ////////////////////////////////////////

    // Carry is dropped every cycle, only the phase is kept
    assign acc_next = {1'b0, acc[ACC_WIDTH-1:0]} + ADD_VALUE;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    assign tick_o = acc[ACC_WIDTH];

    // Increment below half range means no back-to-back carries
    tick_single_cycle: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        tick_o |=> !tick_o
    ) else $error("baud tick high for two cycles");

endmodule

`default_nettype wire

/* pueo_turf_ctl.f */
logic/turf_pkg.sv
logic/turf_gpio_map.sv
logic/uart_baud_tick.sv
logic/turf_id_regs.sv
logic/pueo_turf_ctl.sv
sim/pueo_turf_ctl_tb.sv

/* sim/pueo_turf_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pueo_turf_ctl_tb;

    localparam int READ_TIMEOUT   = 8;
    localparam int WATCHDOG_LIMIT = 20000;
    localparam int RANDOM_ROUNDS  = 16;
    localparam int MAX_RECORDS    = 256;

    logic                 ps_clk = 1'b0;
    logic                 arst_n_i;
    turf_pkg::gpio_word_t emio_gpio_o_i;
    turf_pkg::gpio_word_t emio_gpio_t_i;
    turf_pkg::gpio_word_t emio_gpio_i_o;
    turf_pkg::tio_bits_t  tresetb_i;
    turf_pkg::tio_bits_t  tresetb_o;
    turf_pkg::tio_bits_t  tresetb_oe_o;
    logic [1:0]           gps_timepulse_i;
    logic [1:0]           gps_extint_o;
    logic                 pps_pulse_i;
    logic                 hsk_irq_i;
    logic                 hsk_complete_i;
    logic                 uart_irq_b_i;
    turf_pkg::tio_bits_t  aurora_up_i;
    logic                 rd_stb_i;
    turf_pkg::reg_addr_t  rd_addr_i;
    logic                 rd_valid_o;
    turf_pkg::reg_data_t  rd_data_o;
    logic                 hsk_tick_o;
    logic                 gps_tick_o;

    logic [31:0]          rng_state = 32'heac0;
    // Input word the DUT should show for the pads held right now
    turf_pkg::gpio_word_t last_in_word;

    pueo_turf_ctl dut (
        .ps_clk          (ps_clk),
        .arst_n_i        (arst_n_i),
        .emio_gpio_o_i   (emio_gpio_o_i),
        .emio_gpio_t_i   (emio_gpio_t_i),
        .emio_gpio_i_o   (emio_gpio_i_o),
        .tresetb_i       (tresetb_i),
        .tresetb_o       (tresetb_o),
        .tresetb_oe_o    (tresetb_oe_o),
        .gps_timepulse_i (gps_timepulse_i),
        .gps_extint_o    (gps_extint_o),
        .pps_pulse_i     (pps_pulse_i),
        .hsk_irq_i       (hsk_irq_i),
        .hsk_complete_i  (hsk_complete_i),
        .uart_irq_b_i    (uart_irq_b_i),
        .aurora_up_i     (aurora_up_i),
        .rd_stb_i        (rd_stb_i),
        .rd_addr_i       (rd_addr_i),
        .rd_valid_o      (rd_valid_o),
        .rd_data_o       (rd_data_o),
        .hsk_tick_o      (hsk_tick_o),
        .gps_tick_o      (gps_tick_o)
    );

    always #5 ps_clk = ~ps_clk;

    ////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_gpio_word(input string name, input turf_pkg::gpio_word_t got,
                                   input turf_pkg::gpio_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s expected 0x%h got 0x%h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_tio_bits(input string name, input turf_pkg::tio_bits_t got,
                                  input turf_pkg::tio_bits_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s expected 0x%h got 0x%h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_reg_data(input string name, input turf_pkg::reg_data_t got,
                                  input turf_pkg::reg_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s expected 0x%h got 0x%h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_count(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s expected %0d got %0d",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s expected %b got %b",
                                $time, name, exp, got));
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Pin controls worked out bit by bit from the processor words
    task automatic check_pin_controls(input turf_pkg::gpio_word_t word_o,
                                      input turf_pkg::gpio_word_t word_t);
        turf_pkg::tio_bits_t exp_rst;
        turf_pkg::tio_bits_t exp_oe;
        logic [1:0]          exp_ext;
        for (int k = 0; k < 4; k++) begin
            exp_rst[k] = word_o[turf_pkg::TIO_RESET_LSB + k];
            // Driven only while the pad is not tristated
            exp_oe[k]  = (word_t[turf_pkg::TIO_RESET_LSB + k] == 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            if (word_t[turf_pkg::EXTINT_LSB + k] == 1'b0) begin
                exp_ext[k] = word_o[turf_pkg::EXTINT_LSB + k];
            end else begin
                exp_ext[k] = 1'b0;
            end
        end
        check_tio_bits("tresetb_o", tresetb_o, exp_rst);
        check_tio_bits("tresetb_oe_o", tresetb_oe_o, exp_oe);
        check_tio_bits("gps_extint_o", {2'b00, gps_extint_o}, {2'b00, exp_ext});
    endtask

    ////////////////////////////////////////
    // Register reads
    ////////////////////////////////////////

    task automatic read_and_check(input turf_pkg::reg_addr_t addr,
                                  input turf_pkg::tio_bits_t up,
                                  input turf_pkg::reg_data_t exp);
        int waits;
        @(posedge ps_clk);
        rd_stb_i    <= 1'b1;
        rd_addr_i   <= addr;
        aurora_up_i <= up;
        @(posedge ps_clk);
        rd_stb_i <= 1'b0;
        waits = 0;
        do begin
            @(negedge ps_clk);
            waits++;
        end while (!rd_valid_o && waits < READ_TIMEOUT);
        if (!rd_valid_o) begin
            abort_run("no read response arrived within the timeout");
        end
        check_count("read latency in cycles", waits, 1);
        check_reg_data("rd_data_o", rd_data_o, exp);
    endtask

    // One strobe per cycle, each response one cycle behind its strobe
    task automatic back_to_back_reads();
        turf_pkg::reg_addr_t addrs [4];
        turf_pkg::reg_data_t exp_data [4];
        addrs    = '{turf_pkg::ADDR_IDENT, turf_pkg::ADDR_DATEVERSION,
                     turf_pkg::ADDR_GPIO_IN, turf_pkg::ADDR_IDENT};
        exp_data = '{32'h5455_5246, 32'h8000_0600, {16'h0000, last_in_word}, 32'h5455_5246};
        @(posedge ps_clk);
        rd_stb_i  <= 1'b1;
        rd_addr_i <= addrs[0];
        for (int i = 0; i < 4; i++) begin
            @(posedge ps_clk);
            if (i < 3) begin
                rd_addr_i <= addrs[i + 1];
            end else begin
                rd_stb_i <= 1'b0;
            end
            @(negedge ps_clk);
            check_flag("rd_valid_o", rd_valid_o, 1'b1);
            check_reg_data("rd_data_o", rd_data_o, exp_data[i]);
        end
        @(negedge ps_clk);
        check_flag("rd_valid_o after last strobe", rd_valid_o, 1'b0);
        check_reg_data("rd_data_o held", rd_data_o, exp_data[3]);
    endtask

    ////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////

    task automatic run_vector_file();
        int                   fd;
        int                   rc;
        int                   records;
        string                tok;
        string                rest;
        turf_pkg::gpio_word_t v_o;
        turf_pkg::gpio_word_t v_t;
        turf_pkg::tio_bits_t  v_pad;
        logic [1:0]           v_tp;
        logic                 v_pps;
        logic                 v_hirq;
        logic                 v_hcomp;
        logic                 v_uirq;
        turf_pkg::gpio_word_t x_in;
        turf_pkg::tio_bits_t  x_rst;
        turf_pkg::tio_bits_t  x_oe;
        logic [1:0]           x_ext;
        turf_pkg::tio_bits_t  v_up;
        turf_pkg::reg_addr_t  v_addr;
        turf_pkg::reg_data_t  x_data;
        records = 0;
        fd = $fopen("sim/turf_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/turf_vectors.txt");
        end
        while (records < MAX_RECORDS) begin
            rc = $fscanf(fd, " %s", tok);
            if (rc != 1) begin
                break;
            end
            if (tok == "#") begin
                rc = $fgets(rest, fd);
            end else if (tok == "G") begin
                rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", v_o, v_t, v_pad,
                             v_tp, v_pps, v_hirq, v_hcomp, v_uirq, x_in, x_rst, x_oe, x_ext);
                if (rc != 12) begin
                    abort_run("malformed GPIO record in the vectors file");
                end
                @(posedge ps_clk);
                emio_gpio_o_i   <= v_o;
                emio_gpio_t_i   <= v_t;
                tresetb_i       <= v_pad;
                gps_timepulse_i <= v_tp;
                pps_pulse_i     <= v_pps;
                hsk_irq_i       <= v_hirq;
                hsk_complete_i  <= v_hcomp;
                uart_irq_b_i    <= v_uirq;
                // Room for the two-flop synchronizer
                repeat (4) @(posedge ps_clk);
                @(negedge ps_clk);
                check_gpio_word("emio_gpio_i_o", emio_gpio_i_o, x_in);
                check_gpio_word("emio_gpio_i_o[9:3]", emio_gpio_i_o & 16'h03f8, 16'h0000);
                check_tio_bits("tresetb_o", tresetb_o, x_rst);
                check_tio_bits("tresetb_oe_o", tresetb_oe_o, x_oe);
                check_tio_bits("gps_extint_o", {2'b00, gps_extint_o}, {2'b00, x_ext});
                last_in_word = x_in;
                records++;
            end else if (tok == "R") begin
                rc = $fscanf(fd, "%h %h %h", v_up, v_addr, x_data);
                if (rc != 3) begin
                    abort_run("malformed register record in the vectors file");
                end
                read_and_check(v_addr, v_up, x_data);
                records++;
            end else begin
                abort_run("unknown record type in the vectors file");
            end
        end
        $fclose(fd);
        if (records == 0) begin
            abort_run("the vectors file held no records");
        end
    endtask

    ////////////////////////////////////////
    // Random words and baud ticks
    ////////////////////////////////////////

    task automatic random_pin_checks();
        turf_pkg::gpio_word_t word_o;
        turf_pkg::gpio_word_t word_t;
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            rng_state = next_random(rng_state);
            word_o = rng_state[15:0];
            word_t = rng_state[31:16];
            @(posedge ps_clk);
            emio_gpio_o_i <= word_o;
            emio_gpio_t_i <= word_t;
            repeat (2) @(posedge ps_clk);
            @(negedge ps_clk);
            check_pin_controls(word_o, word_t);
        end
    endtask

    task automatic count_ticks();
        int hsk_count;
        int gps_count;
        hsk_count = 0;
        gps_count = 0;
        for (int c = 0; c < 4096; c++) begin
            @(negedge ps_clk);
            if (c < 1024 && hsk_tick_o) begin
                hsk_count++;
            end
            if (gps_tick_o) begin
                gps_count++;
            end
        end
        check_count("hsk_tick_o pulses in 1024 cycles", hsk_count, 82);
        check_count("gps_tick_o pulses in 4096 cycles", gps_count, 25);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_LIMIT) @(posedge ps_clk);
        abort_run("simulation ran past its cycle limit");
    end

    initial begin
        arst_n_i        = 1'b0;
        emio_gpio_o_i   = '0;
        emio_gpio_t_i   = '1;
        tresetb_i       = '0;
        gps_timepulse_i = '0;
        pps_pulse_i     = 1'b0;
        hsk_irq_i       = 1'b0;
        hsk_complete_i  = 1'b0;
        uart_irq_b_i    = 1'b0;
        aurora_up_i     = '0;
        rd_stb_i        = 1'b0;
        rd_addr_i       = '0;
        last_in_word    = '0;
        repeat (3) @(posedge ps_clk);
        arst_n_i <= 1'b1;

        // Pins released and nothing pending out of reset
        @(negedge ps_clk);
        check_tio_bits("tresetb_oe_o", tresetb_oe_o, 4'h0);
        check_tio_bits("gps_extint_o", {2'b00, gps_extint_o}, 4'h0);
        check_flag("rd_valid_o", rd_valid_o, 1'b0);
        check_flag("hsk_tick_o", hsk_tick_o, 1'b0);
        check_flag("gps_tick_o", gps_tick_o, 1'b0);

        run_vector_file();
        random_pin_checks();
        back_to_back_reads();
        count_ticks();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/turf_vectors.txt */
# GPIO case: G gpio_o gpio_t tresetb_pad timepulse pps hsk_irq hsk_complete uart_irq_b
#   followed by expected input word, reset value, reset enable, extint (all hex)
# Register case: R aurora_up addr expected_data (all hex)
G 0000 ffff 0 0 0 0 0 0 0000 0 0 0
R 0 0 54555246
R 0 1 80000600
R 0 2 00001111
R 0 3 00000000
G f300 0000 f 3 1 1 1 1 fc07 f f 3
R f 2 00003333
R f 3 0000fc07
G a100 5200 5 2 0 1 0 1 5803 a a 1
R 5 2 00001313
R 5 3 00005803
G 3200 c100 a 1 1 0 1 0 a404 3 3 2
R a 2 00003131
R a 3 0000a404
R a 0 54555246
G 5f00 0f00 3 0 0 0 0 1 3001 5 f 0
R 1 2 00001113
R 1 3 00003001
G 0300 fcff c 2 1 0 0 0 cc00 0 0 3
R 8 2 00003111
R 8 3 0000cc00
R 8 1 80000600
